// File: hw/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // System clock and serial line rate
    localparam int clk_freq  = 1_600_000;
    localparam int baud_rate = 100_000;

    // Clock cycles per bit time
    localparam int baud_div = clk_freq / baud_rate;

    // Bit-time counter runs 0 to baud_div-1
    localparam int baud_cnt_w = $clog2(baud_div);

    // Number of channels and width of a channel index
    localparam int num_chan = 4;
    localparam int chan_w   = $clog2(num_chan);

endpackage

`default_nettype wire

// File: hw/uart_msg_pkg.sv
`default_nettype none

package uart_msg_pkg;

    import uart_cfg_pkg::*;

    ////////////////////////////////////////
    // Host side transmit request
    ////////////////////////////////////////

    typedef struct packed {
        logic [chan_w-1:0] chan;
        logic [7:0]        data;
    } tx_req_t;

    ////////////////////////////////////////
    // Received byte as seen by the host
    ////////////////////////////////////////

    // Overrun marks a byte dropped on this channel before this one
    typedef struct packed {
        logic [chan_w-1:0] chan;
        logic [7:0]        data;
        logic              overrun;
    } rx_msg_t;

endpackage

`default_nettype wire

// File: hw/uart_channel.sv
`timescale 1ns/1ps
`default_nettype none

module uart_channel
    import uart_cfg_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rx,
    output logic            tx,
    input  wire logic [7:0] tx_data,
    input  wire logic       tx_start,
    output logic            tx_busy,
    output logic [7:0]      rx_data,
    output logic            rx_done
);

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_t;

    typedef enum logic {
        tx_st_idle,
        tx_st_shift
    } tx_state_t;

    ////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////

    logic [2:0]            rx_sync;
    logic                  rx_s;
    logic                  rx_fall;
    rx_state_t             rx_state;
    logic [baud_cnt_w-1:0] rx_cnt;
    logic                  rx_tick;
    logic [2:0]            rx_bit_cnt;
    logic [7:0]            rx_shift;

    // Three stage synchroniser, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    assign rx_s    = rx_sync[2];
    assign rx_fall = rx_sync[2] & ~rx_sync[1];
    assign rx_tick = (rx_cnt == baud_cnt_w'(baud_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state   <= rx_st_idle;
            rx_cnt     <= '0;
            rx_bit_cnt <= '0;
            rx_done    <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (rx_state)
                rx_st_idle: begin
                    // Preload so the first tick lands mid start bit
                    if (rx_fall) begin
                        rx_state <= rx_st_start;
                        rx_cnt   <= baud_cnt_w'(baud_div / 2 - 1);
                    end
                end
                rx_st_start: begin
                    if (rx_tick) begin
                        rx_cnt     <= '0;
                        rx_bit_cnt <= '0;
                        // Glitch on the line, not a real start bit
                        rx_state   <= rx_s ? rx_st_idle : rx_st_data;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    if (rx_tick) begin
                        rx_cnt <= '0;
                        if (rx_bit_cnt == 3'd7) begin
                            rx_state <= rx_st_stop;
                        end else begin
                            rx_bit_cnt <= rx_bit_cnt + 1'b1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_st_stop: begin
                    if (rx_tick) begin
                        rx_cnt   <= '0;
                        rx_state <= rx_st_idle;
                        // Framing error drops the byte silently
                        rx_done  <= rx_s;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= rx_st_idle;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (rx_state == rx_st_data && rx_tick) begin
            rx_shift <= {rx_s, rx_shift[7:1]};
        end
        if (rx_state == rx_st_stop && rx_tick && rx_s) begin
            rx_data <= rx_shift;
        end
    end

    ////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////

    tx_state_t             tx_state;
    logic [baud_cnt_w-1:0] tx_cnt;
    logic                  tx_tick;
    logic [3:0]            tx_bit_cnt;
    logic [8:0]            tx_shift;

    assign tx_tick = (tx_cnt == baud_cnt_w'(baud_div - 1));

    // Start bit goes out on the load cycle, bit_cnt tracks the bit on the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state   <= tx_st_idle;
            tx_cnt     <= '0;
            tx_bit_cnt <= '0;
            tx_busy    <= 1'b0;
            tx         <= 1'b1;
        end else begin
            case (tx_state)
                tx_st_idle: begin
                    if (tx_start) begin
                        tx_state   <= tx_st_shift;
                        tx_cnt     <= '0;
                        tx_bit_cnt <= '0;
                        tx_busy    <= 1'b1;
                        tx         <= 1'b0;
                    end
                end
                tx_st_shift: begin
                    if (tx_tick) begin
                        tx_cnt <= '0;
                        // End of the stop bit
                        if (tx_bit_cnt == 4'd9) begin
                            tx_state <= tx_st_idle;
                            tx_busy  <= 1'b0;
                        end else begin
                            tx         <= tx_shift[0];
                            tx_bit_cnt <= tx_bit_cnt + 1'b1;
                        end
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Eight data bits then the stop bit, filled with ones behind
    always_ff @(posedge clk) begin
        if (tx_state == tx_st_idle && tx_start) begin
            tx_shift <= {1'b1, tx_data};
        end else if (tx_state == tx_st_shift && tx_tick) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/tx_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tx_dispatch
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     tx_write,
    input  wire tx_req_t                  tx_req,
    output logic [num_chan-1:0]           tx_full,
    output logic [num_chan-1:0]           chan_start,
    output logic [num_chan-1:0][7:0]      chan_data,
    input  wire logic [num_chan-1:0]      chan_busy
);

    logic [num_chan-1:0] slot_full;
    logic [num_chan-1:0] wr_sel;
    logic [num_chan-1:0] wr_take;

    // Channel field selects one slot
    always_comb begin
        wr_sel = '0;
        if (tx_write) begin
            wr_sel[tx_req.chan] = 1'b1;
        end
    end

    // A write to a full slot is dropped
    assign wr_take = wr_sel & ~slot_full;

    // Slot hands its byte over as soon as the channel is idle
    assign chan_start = slot_full & ~chan_busy;
    assign tx_full    = slot_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= '0;
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                if (wr_take[i]) begin
                    slot_full[i] <= 1'b1;
                end else if (chan_start[i]) begin
                    slot_full[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_chan; i++) begin
            if (wr_take[i]) begin
                chan_data[i] <= tx_req.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_collect.sv
`timescale 1ns/1ps
`default_nettype none

module rx_collect
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [num_chan-1:0]      chan_done,
    input  wire logic [num_chan-1:0][7:0] chan_rx_data,
    output logic                          rx_valid,
    output rx_msg_t                       rx_msg
);

    logic [num_chan-1:0]      slot_full;
    logic [num_chan-1:0]      slot_ovr;
    logic [num_chan-1:0][7:0] slot_data;

    logic [chan_w-1:0]        last_served;
    logic [chan_w-1:0]        grant;
    logic                     grant_valid;
    logic [num_chan-1:0]      served;

    ////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////

    // Search starts just after the slot served last
    always_comb begin
        logic [chan_w-1:0] idx;
        grant_valid = 1'b0;
        grant       = last_served;
        for (int i = 1; i <= num_chan; i++) begin
            idx = chan_w'((int'(last_served) + i) % num_chan);
            if (!grant_valid && slot_full[idx]) begin
                grant_valid = 1'b1;
                grant       = idx;
            end
        end
    end

    assign served = grant_valid ? (num_chan'(1) << grant) : '0;

    ////////////////////////////////////////
    // Slots
    ////////////////////////////////////////

    // New byte on a full unserved slot overwrites it and flags the loss
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= '0;
            slot_ovr  <= '0;
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                if (chan_done[i]) begin
                    slot_full[i] <= 1'b1;
                    slot_ovr[i]  <= slot_full[i] & ~served[i];
                end else if (served[i]) begin
                    slot_full[i] <= 1'b0;
                    slot_ovr[i]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_chan; i++) begin
            if (chan_done[i]) begin
                slot_data[i] <= chan_rx_data[i];
            end
        end
    end

    // Registered output, one message per cycle at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid    <= 1'b0;
            rx_msg      <= '0;
            last_served <= chan_w'(num_chan - 1);
        end else begin
            rx_valid <= grant_valid;
            if (grant_valid) begin
                rx_msg.chan    <= grant;
                rx_msg.data    <= slot_data[grant];
                rx_msg.overrun <= slot_ovr[grant];
                last_served    <= grant;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_hub.sv
`timescale 1ns/1ps
`default_nettype none

module uart_hub
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                tx_write,
    input  wire tx_req_t             tx_req,
    output logic [num_chan-1:0]      tx_full,
    input  wire logic [num_chan-1:0] rx_line,
    output logic [num_chan-1:0]      tx_line,
    output logic                     rx_valid,
    output rx_msg_t                  rx_msg
);

    logic [num_chan-1:0]      chan_start;
    logic [num_chan-1:0]      chan_busy;
    logic [num_chan-1:0][7:0] chan_data;
    logic [num_chan-1:0]      chan_done;
    logic [num_chan-1:0][7:0] chan_rx_data;

    // Host writes into per-channel holding slots
    tx_dispatch tx_dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_write   (tx_write),
        .tx_req     (tx_req),
        .tx_full    (tx_full),
        .chan_start (chan_start),
        .chan_data  (chan_data),
        .chan_busy  (chan_busy)
    );

    ////////////////////////////////////////
    // Channel transceivers
    ////////////////////////////////////////

    for (genvar g = 0; g < num_chan; g++) begin : g_chan
        uart_channel uart_channel_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .rx       (rx_line[g]),
            .tx       (tx_line[g]),
            .tx_data  (chan_data[g]),
            .tx_start (chan_start[g]),
            .tx_busy  (chan_busy[g]),
            .rx_data  (chan_rx_data[g]),
            .rx_done  (chan_done[g])
        );
    end

    // Received bytes merged into one tagged stream
    rx_collect rx_collect_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .chan_done    (chan_done),
        .chan_rx_data (chan_rx_data),
        .rx_valid     (rx_valid),
        .rx_msg       (rx_msg)
    );

endmodule

`default_nettype wire

// File: tests/uart_hub_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module uart_hub_assertions
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
(
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                tx_write,
    input wire tx_req_t             tx_req,
    input wire logic [num_chan-1:0] tx_full,
    input wire logic [num_chan-1:0] tx_line,
    input wire logic                rx_valid,
    input wire rx_msg_t             rx_msg
);

    // Lines come out of reset idle
    tx_idle_at_release: assert property (@(posedge clk) $rose(rst_n) |-> tx_line == '1)
        else $error("tx_line was not idle when reset was released");

    // A slot served once cannot be served again in the next cycle
    rx_valid_chan_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid && $past(rx_valid) |-> rx_msg.chan != $past(rx_msg.chan))
        else $error("rx_valid high two cycles in a row on one channel");

    // Accepted write shows up in tx_full one cycle later
    tx_full_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        tx_write && !tx_full[tx_req.chan] |=> tx_full[$past(tx_req.chan)])
        else $error("tx_full not set after a write to an empty slot");

endmodule

bind uart_hub uart_hub_assertions uart_hub_assertions_i (.*);

`default_nettype wire

// File: tests/uart_hub_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_hub_checker
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                tx_write,
    input  wire tx_req_t             tx_req,
    input  wire logic [num_chan-1:0] tx_full,
    input  wire logic [num_chan-1:0] rx_line,
    input  wire logic [num_chan-1:0] tx_line,
    input  wire logic                rx_valid,
    input  wire rx_msg_t             rx_msg,
    output int                       errors,
    output int                       checks,
    output int                       pending
);

    // Frame position counts from the first low sample
    typedef struct packed {
        logic [15:0] cnt;
        logic [7:0]  data;
        logic        bad;
        logic        done;
    } frame_dec_t;

    frame_dec_t tx_dec [num_chan];
    frame_dec_t rx_dec [num_chan];
    logic [7:0] tx_exp [num_chan][$];
    rx_msg_t    rx_exp [num_chan][$];
    logic       running;

    // What the host should see for a byte framed on a channel's rx line
    function automatic rx_msg_t expected_msg(input int ch, input logic [7:0] data);
        rx_msg_t m;
        m.chan    = chan_w'(ch);
        m.data    = data;
        m.overrun = 1'b0;
        return m;
    endfunction

    // One clock of a mid-bit frame decoder
    function automatic frame_dec_t decode_step(input frame_dec_t d, input logic line);
        frame_dec_t n;
        int         pos;
        n      = d;
        n.done = 1'b0;
        if (n.cnt == 16'd0) begin
            if (!line) begin
                n.cnt = 16'd1;
                n.bad = 1'b0;
            end
            return n;
        end
        n.cnt = n.cnt + 16'd1;
        pos   = int'(n.cnt);
        if (pos % baud_div == baud_div / 2) begin
            if (pos / baud_div == 0) begin
                n.bad = n.bad | line;
            end else if (pos / baud_div == 9) begin
                n.bad  = n.bad | ~line;
                n.done = 1'b1;
                n.cnt  = 16'd0;
            end else begin
                n.data = {line, n.data[7:1]};
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Checker: %s", msg);
        errors++;
    endtask

    ////////////////////////////////////////
    // Per-cycle comparison
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic [7:0] exp_byte;
        rx_msg_t    exp_msg;
        if (!rst_n) begin
            running = 1'b0;
            for (int i = 0; i < num_chan; i++) begin
                tx_dec[i] = '0;
                rx_dec[i] = '0;
            end
        end else begin
            // First cycle out of reset
            if (!running) begin
                compare_value("tx_line", 32'(tx_line), 32'({num_chan{1'b1}}));
                compare_value("tx_full", 32'(tx_full), 32'd0);
                compare_value("rx_valid", 32'(rx_valid), 32'd0);
                running = 1'b1;
            end
            if (tx_write && !tx_full[tx_req.chan]) begin
                tx_exp[tx_req.chan].push_back(tx_req.data);
            end
            for (int i = 0; i < num_chan; i++) begin
                tx_dec[i] = decode_step(tx_dec[i], tx_line[i]);
                rx_dec[i] = decode_step(rx_dec[i], rx_line[i]);
                if (tx_dec[i].done && tx_dec[i].bad) begin
                    report_failure($sformatf("bad start or stop bit on tx_line[%0d]", i));
                end else if (tx_dec[i].done && tx_exp[i].size() == 0) begin
                    report_failure($sformatf("tx_line[%0d] sent a byte never written", i));
                end else if (tx_dec[i].done) begin
                    exp_byte = tx_exp[i].pop_front();
                    compare_value($sformatf("tx_line[%0d]", i), 32'(tx_dec[i].data),
                                  32'(exp_byte));
                end
                if (rx_dec[i].done && rx_dec[i].bad) begin
                    report_failure($sformatf("bad start or stop bit on rx_line[%0d]", i));
                end else if (rx_dec[i].done) begin
                    rx_exp[i].push_back(expected_msg(i, rx_dec[i].data));
                end
            end
            if (rx_valid && rx_exp[rx_msg.chan].size() == 0) begin
                report_failure($sformatf("rx_valid on channel %0d with no frame received",
                                         rx_msg.chan));
            end else if (rx_valid) begin
                exp_msg = rx_exp[rx_msg.chan].pop_front();
                compare_value("rx_msg", 32'(rx_msg), 32'(exp_msg));
            end
        end
        pending = 0;
        for (int i = 0; i < num_chan; i++) begin
            pending += tx_exp[i].size() + rx_exp[i].size();
        end
    end

endmodule

`default_nettype wire

// File: tests/uart_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_hub_tb
    import uart_cfg_pkg::*;
    import uart_msg_pkg::*;
();

    // Three loopback rounds, two frames around a dropped write, one driven round
    localparam int num_frames     = 3 * num_chan + 2 + num_chan;
    localparam int frame_cycles   = 10 * baud_div;
    localparam int timeout_cycles = num_frames * frame_cycles * 2 + 1000;

    logic                clk;
    logic                rst_n;
    logic                tx_write;
    tx_req_t             tx_req;
    logic [num_chan-1:0] tx_full;
    logic [num_chan-1:0] rx_line;
    logic [num_chan-1:0] tx_line;
    logic                rx_valid;
    rx_msg_t             rx_msg;

    logic                loopback;
    logic [num_chan-1:0] drv_line;
    logic [7:0]          drv_bytes [num_chan];
    integer              seed;
    int                  errors;
    int                  checks;
    int                  pending;
    int                  tb_errors;

    // Serial loopback or the frame driver on the rx lines
    assign rx_line = loopback ? tx_line : drv_line;

    uart_hub uart_hub_i (.*);

    uart_hub_checker uart_hub_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d frames outstanding", timeout_cycles, pending);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Host and line tasks started on a falling edge
    ////////////////////////////////////////

    task automatic write_byte(input int ch, input logic [7:0] data);
        while (tx_full[ch]) begin
            @(negedge clk);
        end
        tx_write    = 1'b1;
        tx_req.chan = chan_w'(ch);
        tx_req.data = data;
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    task automatic write_to_full(input int ch, input logic [7:0] data);
        if (tx_full[ch] !== 1'b1) begin
            $display("** Error: tx_full[%0d] got %0h expected 1", ch, tx_full[ch]);
            tb_errors++;
        end
        tx_write    = 1'b1;
        tx_req.chan = chan_w'(ch);
        tx_req.data = data;
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    // 8N1 frame with the LSB first
    task automatic send_frame(input int ch, input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            drv_line[ch] = frame[i];
            repeat (baud_div) @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (pending != 0 || tx_full != '0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed      = 32'h0726_19bb;
        rst_n     = 1'b0;
        tx_write  = 1'b0;
        tx_req    = '0;
        loopback  = 1'b1;
        drv_line  = '1;
        tb_errors = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Later rounds queue up in the holding slots behind busy channels
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < num_chan; c++) begin
                write_byte(c, 8'($random(seed)));
            end
        end
        wait_drained();

        // Slot stays full behind the busy channel, so the third write is dropped
        write_byte(2, 8'($random(seed)));
        write_byte(2, 8'($random(seed)));
        write_to_full(2, 8'($random(seed)));
        wait_drained();

        // All four rx lines at once
        for (int c = 0; c < num_chan; c++) begin
            drv_bytes[c] = 8'($random(seed));
        end
        loopback = 1'b0;
        fork
            send_frame(0, drv_bytes[0]);
            send_frame(1, drv_bytes[1]);
            send_frame(2, drv_bytes[2]);
            send_frame(3, drv_bytes[3]);
        join
        wait_drained();
        repeat (2 * baud_div) @(negedge clk);

        $display("Checks: %0d, errors: %0d, host errors: %0d, outstanding frames: %0d",
                 checks, errors, tb_errors, pending);
        if (errors == 0 && tb_errors == 0 && pending == 0 && checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/uart_cfg_pkg.sv
hw/uart_msg_pkg.sv
hw/uart_channel.sv
hw/tx_dispatch.sv
hw/rx_collect.sv
hw/uart_hub.sv
tests/uart_hub_assertions.sv
tests/uart_hub_checker.sv
tests/uart_hub_tb.sv

// File: Makefile
# Verilator build and run of the UART hub testbench

VERILATOR ?= verilator
TOP       ?= uart_hub_tb
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
